// ==== hdl/chip_ctrl_macros.svh ====
`ifndef CHIP_CTRL_MACROS_SVH
`define CHIP_CTRL_MACROS_SVH

// Tag bus clients: core, host, router
`define CHIP_CTRL_NUM_CLIENTS 3

// Frame header field after the start bit
`define CHIP_CTRL_CLIENT_ID_WIDTH 2

`define CHIP_CTRL_DID_WIDTH 4

// One reset bit plus the destination id
`define CHIP_CTRL_PAYLOAD_WIDTH (1 + `CHIP_CTRL_DID_WIDTH)

// Data link
`define CHIP_CTRL_LINK_WIDTH 16
`define CHIP_CTRL_REPEATER_DEPTH 2

`endif

// ==== hdl/tag_pkg.sv ====
`include "chip_ctrl_macros.svh"

package tag_pkg;

  // Client select from the frame header
  // 0 core, 1 host, 2 router, 3 unused
  typedef logic [`CHIP_CTRL_CLIENT_ID_WIDTH-1:0] client_id_t;

  typedef logic [`CHIP_CTRL_DID_WIDTH-1:0] did_t;

  // Payload bits arrive reset first, then did msb first
  typedef struct packed {
    logic reset;
    did_t did;
  } tag_payload_s;

  // One serial lane from master to a client
  typedef struct packed {
    logic op;
    logic data;
  } tag_line_s;

  typedef enum logic [1:0] {
    e_idle,
    e_header,
    e_payload
  } master_state_e;

endpackage

// ==== hdl/link_pkg.sv ====
`include "chip_ctrl_macros.svh"

package link_pkg;

  typedef logic [`CHIP_CTRL_LINK_WIDTH-1:0] link_data_t;

  // Forward half of the ready/valid link
  // Ready travels back as its own wire
  typedef struct packed {
    logic       v;
    link_data_t data;
  } link_s;

endpackage

// ==== hdl/tag_master.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module tag_master (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                                             tag_data_i,
  input  logic                                             tag_en_i,
  output tag_pkg::tag_line_s [`CHIP_CTRL_NUM_CLIENTS-1:0] tag_lines_o
);

  localparam int cnt_width_lp = $clog2(`CHIP_CTRL_PAYLOAD_WIDTH);
  localparam int id_width_lp  = `CHIP_CTRL_CLIENT_ID_WIDTH;

  tag_pkg::master_state_e  state_r;
  tag_pkg::master_state_e  state_n;
  tag_pkg::client_id_t     id_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic                    last_hdr;
  logic                    last_pay;

  assign last_hdr = (cnt_r == cnt_width_lp'(id_width_lp - 1));
  assign last_pay = (cnt_r == cnt_width_lp'(`CHIP_CTRL_PAYLOAD_WIDTH - 1));

  //////////////////////////////////////////////////////////////////////
  // Frame FSM

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      tag_pkg::e_idle:    if (tag_en_i && tag_data_i) state_n = tag_pkg::e_header;
      tag_pkg::e_header:  if (tag_en_i && last_hdr)   state_n = tag_pkg::e_payload;
      tag_pkg::e_payload: if (tag_en_i && last_pay)   state_n = tag_pkg::e_idle;
      default:            state_n = tag_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= tag_pkg::e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      // Counter restarts on every state change
      if (state_r == tag_pkg::e_idle || (state_n != state_r))
        cnt_r <= '0;
      else if (tag_en_i)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // Client id, msb first
  always_ff @(posedge clk_i)
  begin
    if (state_r == tag_pkg::e_header && tag_en_i)
      id_r <= {id_r[id_width_lp-2:0], tag_data_i};
  end

  //////////////////////////////////////////////////////////////////////
  // Payload steering

  // Id 3 matches no line, so that frame is dropped here
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tag_lines_o <= '0;
    else
    begin
      for (int i = 0; i < `CHIP_CTRL_NUM_CLIENTS; i++)
      begin
        tag_lines_o[i] <= '0;
        if (state_r == tag_pkg::e_payload && tag_en_i
            && id_r == tag_pkg::client_id_t'(i))
        begin
          tag_lines_o[i].op   <= 1'b1;
          tag_lines_o[i].data <= tag_data_i;
        end
      end
    end
  end

endmodule

// ==== hdl/tag_client.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module tag_client (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  tag_pkg::tag_line_s    tag_line_i,
  output tag_pkg::tag_payload_s payload_o,
  output logic                  new_o
);

  localparam int width_lp     = `CHIP_CTRL_PAYLOAD_WIDTH;
  localparam int cnt_width_lp = $clog2(width_lp);

  logic [width_lp-1:0]     shift_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic                    done_r;

  // Bits come msb first, so shifting left leaves reset on top
  always_ff @(posedge clk_i)
  begin
    if (tag_line_i.op)
      shift_r <= {shift_r[width_lp-2:0], tag_line_i.data};
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cnt_r  <= '0;
      done_r <= 1'b0;
    end
    else
    begin
      done_r <= 1'b0;
      if (tag_line_i.op)
      begin
        if (cnt_r == cnt_width_lp'(width_lp - 1))
        begin
          cnt_r  <= '0;
          done_r <= 1'b1;
        end
        else
          cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // Only a full frame is ever copied out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      payload_o <= '0;
      new_o     <= 1'b0;
    end
    else
    begin
      new_o <= done_r;
      if (done_r)
        payload_o <= tag_pkg::tag_payload_s'(shift_r);
    end
  end

endmodule

// ==== hdl/link_repeater.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module link_repeater (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            flush_i,
  input  link_pkg::link_s in_i,
  output logic            in_ready_o,
  output link_pkg::link_s out_o,
  input  logic            out_ready_i
);

  localparam int depth_lp     = `CHIP_CTRL_REPEATER_DEPTH;
  localparam int ptr_width_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_width_lp = $clog2(depth_lp + 1);

  link_pkg::link_data_t    mem_r [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    enq;
  logic                    deq;

  // Held closed on both sides while the router is in reset
  assign in_ready_o = !flush_i && (count_r < cnt_width_lp'(depth_lp));
  assign out_o.v    = !flush_i && (count_r != '0);
  assign out_o.data = mem_r[rd_ptr_r];

  assign enq = in_i.v && in_ready_o;
  assign deq = out_o.v && out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= in_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_r + cnt_width_lp'(enq) - cnt_width_lp'(deq);
    end
  end

endmodule

// ==== hdl/chip_ctrl_top.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module chip_ctrl_top (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              tag_data_i,
  input  logic                              tag_en_i,
  input  link_pkg::link_s                   link_in_i,
  input  logic                              link_out_ready_i,
  output logic                              link_in_ready_o,
  output link_pkg::link_s                   link_out_o,
  output logic                              core_reset_o,
  output tag_pkg::did_t                     core_did_o,
  output logic                              host_reset_o,
  output tag_pkg::did_t                     host_did_o,
  output tag_pkg::did_t                     router_did_o,
  output logic [`CHIP_CTRL_NUM_CLIENTS-1:0] tag_new_o
);

  //////////////////////////////////////////////////////////////////////
  // Tag master

  tag_pkg::tag_line_s [`CHIP_CTRL_NUM_CLIENTS-1:0] tag_lines_lo;

  tag_master btm (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tag_data_i  (tag_data_i),
    .tag_en_i    (tag_en_i),
    .tag_lines_o (tag_lines_lo)
  );

  //////////////////////////////////////////////////////////////////////
  // Tag clients

  tag_pkg::tag_payload_s core_tag_data_lo;
  tag_pkg::tag_payload_s host_tag_data_lo;
  tag_pkg::tag_payload_s router_tag_data_lo;

  tag_client btc_core (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tag_line_i (tag_lines_lo[0]),
    .payload_o  (core_tag_data_lo),
    .new_o      (tag_new_o[0])
  );

  tag_client btc_host (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tag_line_i (tag_lines_lo[1]),
    .payload_o  (host_tag_data_lo),
    .new_o      (tag_new_o[1])
  );

  tag_client btc_router (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tag_line_i (tag_lines_lo[2]),
    .payload_o  (router_tag_data_lo),
    .new_o      (tag_new_o[2])
  );

  assign core_reset_o = core_tag_data_lo.reset;
  assign core_did_o   = core_tag_data_lo.did;
  assign host_reset_o = host_tag_data_lo.reset;
  assign host_did_o   = host_tag_data_lo.did;
  assign router_did_o = router_tag_data_lo.did;

  //////////////////////////////////////////////////////////////////////
  // Link repeater, flushed by the router reset bit

  link_repeater repeater (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (router_tag_data_lo.reset),
    .in_i        (link_in_i),
    .in_ready_o  (link_in_ready_o),
    .out_o       (link_out_o),
    .out_ready_i (link_out_ready_i)
  );

endmodule

// ==== dv/chip_ctrl_chk.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module chip_ctrl_chk (
  input logic                              clk_i,
  input logic                              reset_i,
  input logic [`CHIP_CTRL_NUM_CLIENTS-1:0] tag_new_i,
  input link_pkg::link_s                   link_out_i,
  input logic                              link_out_ready_i,
  input logic                              link_in_ready_i,
  input logic                              router_reset_i
);

  int fail_count = 0;

  // A new pulse lasts a single cycle
  new_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    (tag_new_i != '0) |=> ((tag_new_i & $past(tag_new_i)) == '0))
  else
  begin
    $error("tag_new_o held high for more than one cycle");
    fail_count++;
  end

  // Stalled output word must hold, unless the router flush takes it away
  out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (link_out_i.v && !link_out_ready_i) |=> (router_reset_i || $stable(link_out_i)))
  else
  begin
    $error("link_out_o changed while stalled");
    fail_count++;
  end

  flush_closed: assert property (@(posedge clk_i) disable iff (reset_i)
    router_reset_i |-> (!link_out_i.v && !link_in_ready_i))
  else
  begin
    $error("link open while router reset is set");
    fail_count++;
  end

  no_early_new: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (tag_new_i == '0) [*8])
  else
  begin
    $error("tag_new_o pulsed too soon after reset");
    fail_count++;
  end

endmodule

bind chip_ctrl_top chip_ctrl_chk chk (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .tag_new_i        (tag_new_o),
  .link_out_i       (link_out_o),
  .link_out_ready_i (link_out_ready_i),
  .link_in_ready_i  (link_in_ready_o),
  .router_reset_i   (router_tag_data_lo.reset)
);

// ==== dv/chip_ctrl_tb.sv ====
`timescale 1ns/1ps

`include "chip_ctrl_macros.svh"

module chip_ctrl_tb;

  logic                              clk_i = 1'b0;
  logic                              reset_i;
  logic                              tag_data_i;
  logic                              tag_en_i;
  link_pkg::link_s                   link_in_i;
  logic                              link_out_ready_i;
  logic                              link_in_ready_o;
  link_pkg::link_s                   link_out_o;
  logic                              core_reset_o;
  tag_pkg::did_t                     core_did_o;
  logic                              host_reset_o;
  tag_pkg::did_t                     host_did_o;
  tag_pkg::did_t                     router_did_o;
  logic [`CHIP_CTRL_NUM_CLIENTS-1:0] tag_new_o;

  logic [15:0]           lfsr_state = 16'd11;
  int                    errors;
  int                    tests;
  int                    start;
  int                    cycles;
  tag_pkg::tag_payload_s exp_pay [`CHIP_CTRL_NUM_CLIENTS];
  link_pkg::link_data_t  sb [$];

  chip_ctrl_top i_chip_ctrl_top (.*);

  always #50 clk_i = ~clk_i;

  // Taps 16 14 13 11
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r          = {r[14:0], fb};
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic note_error(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int first_error);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == first_error) ? "ok" : "errors");
  endtask

  task automatic check_outputs();
    check_val("core_reset_o", exp_pay[0].reset, core_reset_o);
    check_val("core_did_o", exp_pay[0].did, core_did_o);
    check_val("host_reset_o", exp_pay[1].reset, host_reset_o);
    check_val("host_did_o", exp_pay[1].did, host_did_o);
    check_val("router_did_o", exp_pay[2].did, router_did_o);
  endtask

  // Start bit, client id, payload, msb first, with one paused cycle
  task automatic send_frame(input tag_pkg::client_id_t id, input tag_pkg::tag_payload_s pay);
    logic [7:0] bits;
    int         gap;
    bits = {1'b1, id, pay};
    gap  = 1 + int'(rand_bits(3)) % 6;
    for (int i = 7; i >= 0; i--)
    begin
      if (7 - i == gap)
      begin
        tag_en_i   = 1'b0;
        tag_data_i = (rand_bits(1) != 0);
        @(negedge clk_i);
      end
      tag_en_i   = 1'b1;
      tag_data_i = bits[i];
      @(negedge clk_i);
    end
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
  endtask

  task automatic run_frame(input tag_pkg::client_id_t id, input tag_pkg::tag_payload_s pay);
    int n;
    send_frame(id, pay);
    n = 0;
    while (tag_new_o == '0 && n < 6)
    begin
      @(negedge clk_i);
      n++;
    end
    if (id < `CHIP_CTRL_NUM_CLIENTS)
    begin
      exp_pay[id] = pay;
      if (n == 6)
        note_error("no tag_new_o pulse after the frame");
      check_val("frame latency", 2, n);
      check_val("tag_new_o", 1 << id, tag_new_o);
    end
    else
      check_val("tag_new_o", 0, tag_new_o);
    check_outputs();
  endtask

  // Outputs sampled at the falling edge decide the next rising edge
  task automatic stream_words(input int n);
    int                   sent;
    int                   got;
    int                   t;
    logic                 have_word;
    link_pkg::link_data_t word;
    sent      = 0;
    got       = 0;
    t         = 0;
    have_word = 1'b0;
    word      = '0;
    while ((sent < n || sb.size() != 0) && t < 40 * n)
    begin
      if (!have_word && sent < n && rand_bits(1) != 0)
      begin
        word      = rand_bits(16);
        have_word = 1'b1;
      end
      link_in_i.v      = have_word;
      link_in_i.data   = word;
      link_out_ready_i = (rand_bits(2) != 0);
      if (link_out_o.v && link_out_ready_i)
      begin
        if (sb.size() == 0)
          note_error("link word appeared that was never sent");
        else
          check_val("link_out_o.data", sb.pop_front(), link_out_o.data);
        got++;
      end
      if (have_word && link_in_ready_o)
      begin
        sb.push_back(word);
        sent++;
        have_word = 1'b0;
      end
      @(negedge clk_i);
      t++;
    end
    link_in_i = '0;
    if (t == 40 * n)
      note_error("link stream timed out");
    check_val("link words received", n, got);
  endtask

  initial
  begin
    errors           = 0;
    tests            = 0;
    reset_i          = 1'b1;
    tag_data_i       = 1'b0;
    tag_en_i         = 1'b0;
    link_in_i        = '0;
    link_out_ready_i = 1'b0;
    exp_pay          = '{default: '0};
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    start = errors;
    check_outputs();
    check_val("tag_new_o", 0, tag_new_o);
    check_val("link_out_o.v", 0, link_out_o.v);
    check_val("link_in_ready_o", 1, link_in_ready_o);
    finish_test("reset state", start);

    start = errors;
    run_frame(0, tag_pkg::tag_payload_s'(rand_bits(5)));
    finish_test("core frame", start);

    start = errors;
    run_frame(1, tag_pkg::tag_payload_s'(rand_bits(5)));
    run_frame(3, tag_pkg::tag_payload_s'(rand_bits(5)));
    finish_test("host frame and unused id", start);

    start = errors;
    stream_words(40);
    finish_test("link stream", start);

    ////////////////////////////////////////////////////////////////////
    // Router flush drops the words parked in the repeater

    start            = errors;
    link_out_ready_i = 1'b0;
    cycles           = 0;
    while (link_in_ready_o && cycles < 10)
    begin
      link_in_i.v    = 1'b1;
      link_in_i.data = rand_bits(16);
      @(negedge clk_i);
      cycles++;
    end
    link_in_i = '0;
    if (cycles == 10)
      note_error("repeater never filled up");
    run_frame(2, {1'b1, tag_pkg::did_t'(rand_bits(4))});
    link_in_i.v      = 1'b1;
    link_out_ready_i = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk_i);
      check_val("link_in_ready_o", 0, link_in_ready_o);
      check_val("link_out_o.v", 0, link_out_o.v);
    end
    link_in_i = '0;
    run_frame(2, {1'b0, tag_pkg::did_t'(rand_bits(4))});
    check_val("link_out_o.v", 0, link_out_o.v);
    check_val("link_in_ready_o", 1, link_in_ready_o);
    sb.delete();
    stream_words(8);
    finish_test("router flush", start);

    $display("tests %0d, check errors %0d, assertion failures %0d",
             tests, errors, i_chip_ctrl_top.chk.fail_count);
    if (errors == 0 && i_chip_ctrl_top.chk.fail_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== chip_ctrl.f ====
+incdir+hdl
hdl/tag_pkg.sv
hdl/link_pkg.sv
hdl/tag_master.sv
hdl/tag_client.sv
hdl/link_repeater.sv
hdl/chip_ctrl_top.sv
dv/chip_ctrl_chk.sv
dv/chip_ctrl_tb.sv
